//--- design/vic_pkg.sv
package vic_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    // Number of external interrupt lines
    parameter int NUM_SRC = 31;

    // Config bits per line
    parameter int CFG_W = 4;

    // Vector number width, enough for 31 lines
    parameter int ID_W = 5;

    // Bit positions inside one config field
    parameter int CFG_EN   = 3;
    parameter int CFG_RISE = 2;
    parameter int CFG_FALL = 1;
    // Active level, only when rise and fall are both clear
    parameter int CFG_LVL  = 0;

    ////////////////////
    // Types
    ////////////////////

    // One bit per line
    typedef logic [NUM_SRC-1:0] src_vec_t;

    // All config fields, field k at bits 4k+3..4k
    typedef logic [NUM_SRC*CFG_W-1:0] cfg_vec_t;

    // Vector number sent to the CPU
    typedef logic [ID_W-1:0] irq_id_t;

    // CPU service cycle
    typedef enum logic [1:0] {
        SVC_IDLE,
        SVC_REQ,
        SVC_SERVE
    } svc_state_t;

endpackage

//--- design/vic_prio_sel.sv
`timescale 1ns/1ps

module vic_prio_sel #(
    parameter int N_SRC = vic_pkg::NUM_SRC
) (
    input  logic              o_IRQ,
    input  logic              i_rst_n,
    input  vic_pkg::src_vec_t i_pending,
    input  logic              i_ready,
    output logic              o_irq_req,
    output vic_pkg::irq_id_t  o_irq_addr
);

    import vic_pkg::*;

    // Lowest pending index
    irq_id_t win_id;
    logic    any_pend;
    logic    grant;

    ////////////////////
    // Priority encoder
    ////////////////////

    // Scan downward so the lowest set bit is the last write
    always_comb begin
        win_id = '0;
        for (int k = N_SRC - 1; k >= 0; k--) begin
            if (i_pending[k]) begin
                win_id = irq_id_t'(k);
            end
        end
    end

    assign any_pend = |i_pending[N_SRC-1:0];

    // No back-to-back pulse while service still sees IDLE
    assign grant = i_ready && any_pend && !o_irq_req;

    ////////////////////
    // Request output
    ////////////////////

    always_ff @(posedge o_IRQ) begin
        if (!i_rst_n) begin
            o_irq_req  <= 1'b0;
            o_irq_addr <= '0;
        end else begin
            // One-cycle pulse
            o_irq_req <= grant;
            // Address holds until the next grant
            if (grant) begin
                o_irq_addr <= win_id;
            end
        end
    end

endmodule

//--- design/vic_service.sv
`timescale 1ns/1ps

module vic_service (
    input  logic o_IRQ,
    input  logic i_rst_n,
    input  logic i_en,
    input  logic i_cpu_busy,
    input  logic i_req,
    output logic o_ready,
    output logic o_done
);

    import vic_pkg::*;

    svc_state_t state;
    svc_state_t state_nxt;
    logic       done_nxt;

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        state_nxt = state;
        done_nxt  = 1'b0;
        case (state)
            // Wait for a request pulse
            SVC_IDLE: begin
                if (i_req) begin
                    state_nxt = SVC_REQ;
                end
            end
            // Wait for the CPU to pick it up
            // A busy drop here is ignored
            SVC_REQ: begin
                if (i_cpu_busy) begin
                    state_nxt = SVC_SERVE;
                end
            end
            // Busy falling edge ends the handler
            SVC_SERVE: begin
                if (!i_cpu_busy) begin
                    state_nxt = SVC_IDLE;
                    done_nxt  = 1'b1;
                end
            end
            default: begin
                state_nxt = SVC_IDLE;
            end
        endcase
    end

    ////////////////////
    // State registers
    ////////////////////

    always_ff @(posedge o_IRQ) begin
        if (!i_rst_n) begin
            state  <= SVC_IDLE;
            o_done <= 1'b0;
        end else begin
            state  <= state_nxt;
            o_done <= done_nxt;
        end
    end

    // Held off during the done cycle while the served bit clears
    assign o_ready = (state == SVC_IDLE) && i_en && !o_done;

endmodule

//--- design/vic_src_detect.sv
`timescale 1ns/1ps

module vic_src_detect (
    input  logic              o_IRQ,
    input  logic              i_rst_n,
    input  vic_pkg::src_vec_t i_ext,
    input  vic_pkg::cfg_vec_t i_cfg,
    input  logic              i_done,
    input  vic_pkg::irq_id_t  i_done_id,
    output vic_pkg::src_vec_t o_pending
);

    import vic_pkg::*;

    // Two-flop synchronizer plus previous sample
    src_vec_t sync_1;
    src_vec_t sync_2;
    src_vec_t prev;

    // Per-line edge flags
    src_vec_t rise;
    src_vec_t fall;
    src_vec_t change;

    // Level lines wait for a first change after reset
    src_vec_t armed;
    src_vec_t armed_nxt;

    // Set requests and level-still-active flags
    src_vec_t set_hit;
    src_vec_t lvl_hold;
    src_vec_t clr_mask;

    ////////////////////
    // Synchronizer
    ////////////////////

    // Free running, settles while reset is held
    always_ff @(posedge o_IRQ) begin
        sync_1 <= i_ext;
        sync_2 <= sync_1;
        prev   <= sync_2;
    end

    assign rise   = sync_2 & ~prev;
    assign fall   = ~sync_2 & prev;
    assign change = sync_2 ^ prev;

    // Arming takes effect on the same edge as the change
    assign armed_nxt = armed | change;

    ////////////////////
    // Qualification
    ////////////////////

    always_comb begin
        logic [CFG_W-1:0] fld;
        logic             is_lvl;
        logic             edge_hit;

        set_hit  = '0;
        lvl_hold = '0;
        fld      = '0;
        is_lvl   = 1'b0;
        edge_hit = 1'b0;
        for (int k = 0; k < NUM_SRC; k++) begin
            fld = i_cfg[k*CFG_W +: CFG_W];
            // Level mode when no edge is selected
            is_lvl   = !fld[CFG_RISE] && !fld[CFG_FALL];
            edge_hit = (fld[CFG_RISE] && rise[k]) || (fld[CFG_FALL] && fall[k]);
            // Enabled, armed level line sitting at its active value
            lvl_hold[k] = fld[CFG_EN] && is_lvl && armed_nxt[k]
                          && (sync_2[k] == fld[CFG_LVL]);
            set_hit[k]  = (fld[CFG_EN] && edge_hit) || lvl_hold[k];
        end
    end

    // Served line drops out unless its level still holds
    assign clr_mask = i_done ? ((src_vec_t'(1) << i_done_id) & ~lvl_hold) : '0;

    ////////////////////
    // Pending bits
    ////////////////////

    always_ff @(posedge o_IRQ) begin
        if (!i_rst_n) begin
            armed     <= '0;
            o_pending <= '0;
        end else begin
            armed     <= armed_nxt;
            // New event wins over a clear on the same edge
            o_pending <= set_hit | (o_pending & ~clr_mask);
        end
    end

endmodule

//--- design/vic_top.sv
`timescale 1ns/1ps

module vic_top #(
    parameter int N_SRC = vic_pkg::NUM_SRC
) (
    input  logic              o_IRQ,
    input  logic              i_rst_n,
    input  vic_pkg::src_vec_t i_ext,
    input  vic_pkg::cfg_vec_t i_cfg,
    input  logic              i_en,
    input  logic              i_cpu_busy,
    output logic              o_irq_req,
    output vic_pkg::irq_id_t  o_irq_addr
);

    import vic_pkg::*;

    // Pending bits into the encoder
    src_vec_t pending;

    // Service handshake
    logic ready;
    logic done;

    ////////////////////
    // Line detection
    ////////////////////

    // Clear target comes back from the held vector number
    vic_src_detect u_src_detect (
        .o_IRQ     (o_IRQ),
        .i_rst_n   (i_rst_n),
        .i_ext     (i_ext),
        .i_cfg     (i_cfg),
        .i_done    (done),
        .i_done_id (o_irq_addr),
        .o_pending (pending)
    );

    ////////////////////
    // Service tracking
    ////////////////////

    vic_service u_service (
        .o_IRQ      (o_IRQ),
        .i_rst_n    (i_rst_n),
        .i_en       (i_en),
        .i_cpu_busy (i_cpu_busy),
        .i_req      (o_irq_req),
        .o_ready    (ready),
        .o_done     (done)
    );

    ////////////////////
    // Request select
    ////////////////////

    vic_prio_sel #(
        .N_SRC (N_SRC)
    ) u_prio_sel (
        .o_IRQ      (o_IRQ),
        .i_rst_n    (i_rst_n),
        .i_pending  (pending),
        .i_ready    (ready),
        .o_irq_req  (o_irq_req),
        .o_irq_addr (o_irq_addr)
    );

endmodule

//--- filelist.f
design/vic_pkg.sv
design/vic_src_detect.sv
design/vic_service.sv
design/vic_prio_sel.sv
design/vic_top.sv
tests/vic_assert.sv
tests/vic_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the interrupt controller testbench with Verilator
set -euo pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module vic_tb \
    -f filelist.f \
    -Mdir "$BUILD_DIR" \
    -o Vvic_tb

"$BUILD_DIR"/Vvic_tb +verilator+error+limit+1000 2>&1 | tee "$LOG"

if grep -qx "TB PASSED" "$LOG"; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi

//--- tests/vic_assert.sv
`timescale 1ns/1ps

module vic_assert (
    input logic             o_IRQ,
    input logic             i_rst_n,
    input logic             i_cpu_busy,
    input logic             i_irq_req,
    input vic_pkg::irq_id_t i_irq_addr
);

    // Failed assertion tally
    int fail_cnt = 0;

    ////////////////////
    // Request rules
    ////////////////////

    // Pulse lasts one cycle
    req_one_cycle: assert property (
        @(posedge o_IRQ) disable iff (!i_rst_n) i_irq_req |=> !i_irq_req
    ) else begin
        $error("o_irq_req high for two cycles");
        fail_cnt++;
    end

    // CPU must be free when asked
    req_not_busy: assert property (
        @(posedge o_IRQ) disable iff (!i_rst_n) i_irq_req |-> !i_cpu_busy
    ) else begin
        $error("request while the CPU is busy");
        fail_cnt++;
    end

    ////////////////////
    // Reset state
    ////////////////////

    reset_outputs: assert property (
        @(posedge o_IRQ) !i_rst_n |=> (!i_irq_req && i_irq_addr == '0)
    ) else begin
        $error("outputs not zero after a reset edge");
        fail_cnt++;
    end

endmodule

bind vic_top vic_assert u_assert (
    .o_IRQ      (o_IRQ),
    .i_rst_n    (i_rst_n),
    .i_cpu_busy (i_cpu_busy),
    .i_irq_req  (o_irq_req),
    .i_irq_addr (o_irq_addr)
);

//--- tests/vic_tb.sv
`timescale 1ns/1ps

module vic_tb;

    import vic_pkg::*;

    ////////////////////
    // Run length
    ////////////////////

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 3;
    localparam int QUIET        = 12;
    localparam int N_CYCLES     = 4000;
    localparam int MARGIN       = 200;
    localparam int RUN_CYCLES   = RESET_CYCLES + 1 + QUIET + N_CYCLES;
    localparam int MIN_REQS     = 20;

    // Model service phases
    localparam int ST_IDLE  = 0;
    localparam int ST_REQ   = 1;
    localparam int ST_SERVE = 2;

    // DUT inputs, all set at time zero
    logic     o_IRQ = 1'b0;
    logic     i_rst_n = 1'b0;
    src_vec_t i_ext = '0;
    cfg_vec_t i_cfg = '0;
    logic     i_en = 1'b1;
    logic     i_cpu_busy = 1'b0;
    logic     o_irq_req;
    irq_id_t  o_irq_addr;

    integer seed;

    // Reference model state
    src_vec_t m_s1;
    src_vec_t m_s2;
    src_vec_t m_prev;
    src_vec_t m_armed;
    src_vec_t m_pend;
    int       m_state;
    logic     m_done;
    logic     m_req;
    irq_id_t  m_addr;

    // CPU model and enable stretches
    logic cpu_active = 1'b0;
    int   wait_cnt = 0;
    int   hold_cnt = 0;
    int   en_cnt = 0;

    int req_err = 0;
    int addr_err = 0;
    int other_err = 0;
    int req_cnt = 0;

    vic_top #(
        .N_SRC (NUM_SRC)
    ) DUT (
        .o_IRQ      (o_IRQ),
        .i_rst_n    (i_rst_n),
        .i_ext      (i_ext),
        .i_cfg      (i_cfg),
        .i_en       (i_en),
        .i_cpu_busy (i_cpu_busy),
        .o_irq_req  (o_irq_req),
        .o_irq_addr (o_irq_addr)
    );

    always #(PERIOD / 2) o_IRQ = ~o_IRQ;

    ////////////////////
    // Reference model
    ////////////////////

    // Lowest set index, upward search
    function automatic irq_id_t lowest_set(input src_vec_t v);
        irq_id_t id;
        logic    found;
        id    = '0;
        found = 1'b0;
        for (int k = 0; k < NUM_SRC; k++) begin
            if (v[k] && !found) begin
                id    = irq_id_t'(k);
                found = 1'b1;
            end
        end
        return id;
    endfunction

    task automatic model_step();
        src_vec_t         arm_now;
        src_vec_t         hold;
        src_vec_t         set_v;
        src_vec_t         clr_v;
        logic [CFG_W-1:0] fld;
        logic             ready;
        logic             grant;
        int               nxt_state;
        logic             nxt_done;
        // Any change on the delayed line arms it
        arm_now = m_armed | (m_s2 ^ m_prev);
        hold    = '0;
        set_v   = '0;
        clr_v   = '0;
        for (int k = 0; k < NUM_SRC; k++) begin
            fld = i_cfg[k*CFG_W +: CFG_W];
            if (fld[3]) begin
                if (fld[2] && m_s2[k] && !m_prev[k]) begin
                    set_v[k] = 1'b1;
                end
                if (fld[1] && !m_s2[k] && m_prev[k]) begin
                    set_v[k] = 1'b1;
                end
                // Level mode, armed and active
                if (fld[2:1] == 2'b00 && arm_now[k] && m_s2[k] == fld[0]) begin
                    hold[k]  = 1'b1;
                    set_v[k] = 1'b1;
                end
            end
        end
        if (m_done && !hold[m_addr]) begin
            clr_v[m_addr] = 1'b1;
        end
        // Ready only when idle, enabled, and past the done cycle
        ready = (m_state == ST_IDLE) && i_en && !m_done;
        grant = ready && (m_pend != '0) && !m_req;
        nxt_state = m_state;
        nxt_done  = 1'b0;
        if (m_state == ST_IDLE && m_req) begin
            nxt_state = ST_REQ;
        end else if (m_state == ST_REQ && i_cpu_busy) begin
            nxt_state = ST_SERVE;
        end else if (m_state == ST_SERVE && !i_cpu_busy) begin
            nxt_state = ST_IDLE;
            nxt_done  = 1'b1;
        end
        // Line delay runs through reset
        m_prev = m_s2;
        m_s2   = m_s1;
        m_s1   = i_ext;
        if (!i_rst_n) begin
            m_armed = '0;
            m_pend  = '0;
            m_state = ST_IDLE;
            m_done  = 1'b0;
            m_req   = 1'b0;
            m_addr  = '0;
        end else begin
            if (grant) begin
                m_addr = lowest_set(m_pend);
            end
            m_armed = arm_now;
            m_pend  = set_v | (m_pend & ~clr_v);
            m_state = nxt_state;
            m_done  = nxt_done;
            m_req   = grant;
        end
    endtask

    always @(posedge o_IRQ) begin
        model_step();
    end

    ////////////////////
    // Stimulus and checks
    ////////////////////

    // Mix of rise, fall, both, level high, level low, disabled
    task automatic build_cfg();
        int               mode;
        logic [CFG_W-1:0] fld;
        for (int k = 0; k < NUM_SRC; k++) begin
            mode = {$random(seed)} % 8;
            case (mode)
                0, 1: fld = 4'b1100;
                2: fld = 4'b1010;
                3: fld = 4'b1110;
                4, 5: fld = 4'b1001;
                6: fld = 4'b1000;
                default: fld = {1'b0, 3'($random(seed))};
            endcase
            i_cfg[k*CFG_W +: CFG_W] = fld;
        end
    endtask

    task automatic check_outputs();
        if (o_irq_req !== m_req) begin
            req_err++;
            $display("error at time %0t: o_irq_req is %b, model expects %b",
                     $time, o_irq_req, m_req);
        end
        if (o_irq_addr !== m_addr) begin
            addr_err++;
            $display("error at time %0t: o_irq_addr is %0d, model expects %0d",
                     $time, o_irq_addr, m_addr);
        end
        if (o_irq_req && !i_en) begin
            other_err++;
            $display("error at time %0t: request issued while enable was low", $time);
        end
        if (o_irq_req && cpu_active) begin
            other_err++;
            $display("error at time %0t: second request before service ended", $time);
        end
        if (o_irq_req) begin
            req_cnt++;
        end
    endtask

    // Nothing may fire before any line has moved
    task automatic check_quiet();
        if (o_irq_req !== 1'b0 || o_irq_addr !== '0) begin
            other_err++;
            $display("error at time %0t: request raised before any line changed", $time);
        end
    endtask

    // Busy 1 to 4 cycles after a request, held 2 to 10 cycles
    task automatic drive_cpu();
        if (o_irq_req) begin
            cpu_active = 1'b1;
            wait_cnt   = 1 + {$random(seed)} % 4;
            hold_cnt   = 2 + {$random(seed)} % 9;
        end else if (cpu_active) begin
            if (wait_cnt > 0) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    i_cpu_busy = 1'b1;
                end
            end else if (hold_cnt > 0) begin
                hold_cnt--;
                if (hold_cnt == 0) begin
                    i_cpu_busy = 1'b0;
                    cpu_active = 1'b0;
                end
            end
        end
    endtask

    task automatic drive_enable();
        if (en_cnt > 0) begin
            en_cnt--;
            if (en_cnt == 0) begin
                i_en = 1'b1;
            end
        end else if ({$random(seed)} % 50 == 0) begin
            i_en   = 1'b0;
            en_cnt = 5 + {$random(seed)} % 16;
        end
    endtask

    task automatic drive_lines();
        int idx;
        if ({$random(seed)} % 3 == 0) begin
            idx        = {$random(seed)} % NUM_SRC;
            i_ext[idx] = ~i_ext[idx];
        end
    endtask

    initial begin
        int total;
        seed = 32'hc480_a2f4;
        build_cfg();
        // Random start levels, some level lines begin active
        i_ext = src_vec_t'($random(seed));
        repeat (RESET_CYCLES) @(posedge o_IRQ);
        @(negedge o_IRQ);
        check_quiet();
        i_rst_n = 1'b1;
        repeat (QUIET) begin
            @(negedge o_IRQ);
            check_quiet();
            check_outputs();
        end
        repeat (N_CYCLES) begin
            @(negedge o_IRQ);
            check_outputs();
            drive_cpu();
            drive_enable();
            drive_lines();
        end
        if (req_cnt < MIN_REQS) begin
            other_err++;
            $display("too few requests seen: %0d", req_cnt);
        end
        total = req_err + addr_err + other_err + DUT.u_assert.fail_cnt;
        $display("errors: request=%0d address=%0d protocol=%0d assertion=%0d",
                 req_err, addr_err, other_err, DUT.u_assert.fail_cnt);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((RUN_CYCLES + MARGIN) * PERIOD);
        $display("timeout: run did not finish within %0d cycles", RUN_CYCLES + MARGIN);
        $display("TB FAILED");
        $finish;
    end

endmodule
